/* creg_subsystem.f */
rtl/creg_pkg.sv
rtl/interrupt_controller.sv
rtl/thread_context.sv
rtl/control_registers.sv
rtl/creg_subsystem.sv
verification/clock_gen.sv
verification/creg_subsystem_tb.sv

/* rtl/control_registers.sv */
module control_registers
    #(parameter int CORE_ID = 0)
    (input                              clk,
    input                               reset,
    input creg_pkg::creg_access_t       creg_access,
    input creg_pkg::flags_t             current_flags[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::flags_t             saved_flags[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::scalar_t            eret_address[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::subcycle_t          eret_subcycle[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::trap_cause_t        trap_cause[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::scalar_t            trap_address[creg_pkg::THREADS_PER_CORE],
    input creg_pkg::scalar_t            scratchpad[creg_pkg::THREADS_PER_CORE][2],
    input [creg_pkg::NUM_INTERRUPTS - 1:0] pending_word[creg_pkg::THREADS_PER_CORE],
    input [creg_pkg::NUM_INTERRUPTS - 1:0] mask_word[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           read_value,
    output creg_pkg::scalar_t           trap_handler,
    output creg_pkg::scalar_t           tlb_miss_handler,
    output creg_pkg::asid_t             current_asid[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           page_dir[creg_pkg::THREADS_PER_CORE]);

    creg_pkg::scalar_t cycle_count;
    creg_pkg::scalar_t read_next;

    // Place a flags value in the low bits of an otherwise zero word
    function automatic creg_pkg::scalar_t flags_word(creg_pkg::flags_t flags);
        creg_pkg::creg_value_u word;

        word.raw = '0;
        word.flag_view.flags = flags;
        return word.raw;
    endfunction

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            trap_handler <= '0;
            tlb_miss_handler <= '0;
            cycle_count <= '0;
            for (int t = 0; t < creg_pkg::THREADS_PER_CORE; t++)
            begin
                current_asid[t] <= '0;
                page_dir[t] <= '0;
            end
        end
        else
        begin
            cycle_count <= cycle_count + 1'b1;

            if (creg_access.write_en)
            begin
                case (creg_access.index)
                    creg_pkg::CR_TRAP_HANDLER:
                        trap_handler <= creg_access.value.raw;
                    creg_pkg::CR_TLB_MISS_HANDLER:
                        tlb_miss_handler <= creg_access.value.raw;
                    creg_pkg::CR_CURRENT_ASID:
                        current_asid[creg_access.thread] <=
                            creg_access.value.raw[creg_pkg::ASID_WIDTH - 1:0];
                    creg_pkg::CR_PAGE_DIR:
                        page_dir[creg_access.thread] <= creg_access.value.raw;
                    default:
                        ;
                endcase
            end
        end
    end

    // Read select for the thread named in the access
    always_comb
    begin
        case (creg_access.index)
            creg_pkg::CR_FLAGS:
                read_next = flags_word(current_flags[creg_access.thread]);
            creg_pkg::CR_SAVED_FLAGS:
                read_next = flags_word(saved_flags[creg_access.thread]);
            creg_pkg::CR_THREAD_ID:
                read_next = {CORE_ID[31 - $bits(creg_pkg::thread_idx_t):0], creg_access.thread};
            creg_pkg::CR_TRAP_PC:
                read_next = eret_address[creg_access.thread];
            creg_pkg::CR_TRAP_CAUSE:
                read_next = creg_pkg::scalar_t'(trap_cause[creg_access.thread]);
            creg_pkg::CR_TRAP_HANDLER:
                read_next = trap_handler;
            creg_pkg::CR_TRAP_ADDRESS:
                read_next = trap_address[creg_access.thread];
            creg_pkg::CR_TLB_MISS_HANDLER:
                read_next = tlb_miss_handler;
            creg_pkg::CR_CYCLE_COUNT:
                read_next = cycle_count;
            creg_pkg::CR_SCRATCHPAD0:
                read_next = scratchpad[creg_access.thread][0];
            creg_pkg::CR_SCRATCHPAD1:
                read_next = scratchpad[creg_access.thread][1];
            creg_pkg::CR_SUBCYCLE:
                read_next = creg_pkg::scalar_t'(eret_subcycle[creg_access.thread]);
            creg_pkg::CR_CURRENT_ASID:
                read_next = creg_pkg::scalar_t'(current_asid[creg_access.thread]);
            creg_pkg::CR_PAGE_DIR:
                read_next = page_dir[creg_access.thread];
            creg_pkg::CR_INTERRUPT_PENDING:
                read_next = creg_pkg::scalar_t'(pending_word[creg_access.thread]);
            creg_pkg::CR_INTERRUPT_MASK:
                read_next = creg_pkg::scalar_t'(mask_word[creg_access.thread]);
            // Trigger and ack are write only, like unmapped numbers
            default:
                read_next = '1;
        endcase
    end

    // Read result holds until the next read strobe
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_value <= '0;
        else if (creg_access.read_en)
            read_value <= read_next;
    end

    // The data stage issues either a creg load or a creg store, not both
    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(creg_access.read_en && creg_access.write_en))
        else $error("creg read and write in the same cycle");

endmodule

/* rtl/creg_pkg.sv */
package creg_pkg;

    localparam int THREADS_PER_CORE = 4;
    localparam int NUM_INTERRUPTS = 16;
    localparam int ASID_WIDTH = 8;
    localparam int SUBCYCLE_WIDTH = 4;

    typedef logic [31:0] scalar_t;
    typedef logic [$clog2(THREADS_PER_CORE) - 1:0] thread_idx_t;
    typedef logic [THREADS_PER_CORE - 1:0] thread_bitmap_t;
    typedef logic [SUBCYCLE_WIDTH - 1:0] subcycle_t;
    typedef logic [ASID_WIDTH - 1:0] asid_t;

    // Register numbers used by the creg load and store instructions
    typedef enum logic [4:0] {
        CR_THREAD_ID         = 5'd0,
        CR_TRAP_HANDLER      = 5'd1,
        CR_TRAP_PC           = 5'd2,
        CR_TRAP_CAUSE        = 5'd3,
        CR_FLAGS             = 5'd4,
        CR_TRAP_ADDRESS      = 5'd5,
        CR_CYCLE_COUNT       = 5'd6,
        CR_TLB_MISS_HANDLER  = 5'd7,
        CR_SAVED_FLAGS       = 5'd8,
        CR_CURRENT_ASID      = 5'd9,
        CR_PAGE_DIR          = 5'd10,
        CR_SCRATCHPAD0       = 5'd11,
        CR_SCRATCHPAD1       = 5'd12,
        CR_SUBCYCLE          = 5'd13,
        CR_INTERRUPT_MASK    = 5'd14,
        CR_INTERRUPT_ACK     = 5'd15,
        CR_INTERRUPT_PENDING = 5'd16,
        CR_INTERRUPT_TRIGGER = 5'd17
    } creg_index_t;

    typedef enum logic [3:0] {
        TT_RESET      = 4'd0,
        TT_ILLEGAL    = 4'd1,
        TT_PRIVILEGED = 4'd2,
        TT_INTERRUPT  = 4'd3,
        TT_TLB_MISS   = 4'd4,
        TT_PAGE_FAULT = 4'd5
    } trap_type_t;

    typedef struct packed {
        logic is_store;
        logic is_data_access;
        trap_type_t trap_type;
    } trap_cause_t;

    typedef struct packed {
        logic supervisor_en;
        logic mmu_en;
        logic interrupt_en;
    } flags_t;

    // A register data word, taken either as a whole or as the flags layout
    typedef union packed {
        scalar_t raw;
        struct packed {
            logic [28:0] pad;
            flags_t flags;
        } flag_view;
    } creg_value_u;

    typedef struct packed {
        logic read_en;
        logic write_en;
        creg_index_t index;
        thread_idx_t thread;
        creg_value_u value;
    } creg_access_t;

    typedef struct packed {
        logic valid;
        trap_cause_t cause;
        scalar_t pc;
        scalar_t access_addr;
        thread_idx_t thread;
        subcycle_t subcycle;
    } trap_event_t;

    typedef struct packed {
        logic valid;
        thread_idx_t thread;
    } eret_t;

endpackage

/* rtl/creg_subsystem.sv */
module creg_subsystem
    #(parameter int CORE_ID = 0)
    (input                              clk,
    input                               reset,
    input [creg_pkg::NUM_INTERRUPTS - 1:0] interrupt_req,
    input creg_pkg::creg_access_t       creg_access,
    input creg_pkg::trap_event_t        trap,
    input creg_pkg::eret_t              eret,
    output creg_pkg::scalar_t           read_value,
    output creg_pkg::flags_t            current_flags[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           eret_address[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::subcycle_t         eret_subcycle[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::thread_bitmap_t    interrupt_pending,
    output creg_pkg::scalar_t           trap_handler,
    output creg_pkg::scalar_t           tlb_miss_handler,
    output creg_pkg::asid_t             current_asid[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           page_dir[creg_pkg::THREADS_PER_CORE]);

    creg_pkg::flags_t saved_flags[creg_pkg::THREADS_PER_CORE];
    creg_pkg::trap_cause_t trap_cause[creg_pkg::THREADS_PER_CORE];
    creg_pkg::scalar_t trap_address[creg_pkg::THREADS_PER_CORE];
    creg_pkg::scalar_t scratchpad[creg_pkg::THREADS_PER_CORE][2];
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] pending_word[creg_pkg::THREADS_PER_CORE];
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] mask_word[creg_pkg::THREADS_PER_CORE];

    interrupt_controller interrupt_controller(
        .clk(clk),
        .reset(reset),
        .interrupt_req(interrupt_req),
        .creg_access(creg_access),
        .interrupt_pending(interrupt_pending),
        .pending_word(pending_word),
        .mask_word(mask_word));

    thread_context thread_context(
        .clk(clk),
        .reset(reset),
        .creg_access(creg_access),
        .trap(trap),
        .eret(eret),
        .current_flags(current_flags),
        .eret_address(eret_address),
        .eret_subcycle(eret_subcycle),
        .saved_flags(saved_flags),
        .trap_cause(trap_cause),
        .trap_address(trap_address),
        .scratchpad(scratchpad));

    control_registers #(.CORE_ID(CORE_ID)) control_registers(
        .clk(clk),
        .reset(reset),
        .creg_access(creg_access),
        .current_flags(current_flags),
        .saved_flags(saved_flags),
        .eret_address(eret_address),
        .eret_subcycle(eret_subcycle),
        .trap_cause(trap_cause),
        .trap_address(trap_address),
        .scratchpad(scratchpad),
        .pending_word(pending_word),
        .mask_word(mask_word),
        .read_value(read_value),
        .trap_handler(trap_handler),
        .tlb_miss_handler(tlb_miss_handler),
        .current_asid(current_asid),
        .page_dir(page_dir));

endmodule

/* rtl/interrupt_controller.sv */
module interrupt_controller(
    input                                       clk,
    input                                       reset,
    input [creg_pkg::NUM_INTERRUPTS - 1:0]      interrupt_req,
    input creg_pkg::creg_access_t               creg_access,
    output creg_pkg::thread_bitmap_t            interrupt_pending,
    output logic [creg_pkg::NUM_INTERRUPTS - 1:0] pending_word[creg_pkg::THREADS_PER_CORE],
    output logic [creg_pkg::NUM_INTERRUPTS - 1:0] mask_word[creg_pkg::THREADS_PER_CORE]);

    logic [creg_pkg::NUM_INTERRUPTS - 1:0] interrupt_req_prev;
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] interrupt_edge;
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] trigger_type;
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] edge_latched[creg_pkg::THREADS_PER_CORE];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            interrupt_req_prev <= '0;
        else
            interrupt_req_prev <= interrupt_req;
    end

    // Rising edge on any request line
    assign interrupt_edge = interrupt_req & ~interrupt_req_prev;

    // One trigger type per line, shared by all threads
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            trigger_type <= '0;
        else if (creg_access.write_en && creg_access.index == creg_pkg::CR_INTERRUPT_TRIGGER)
            trigger_type <= creg_access.value.raw[creg_pkg::NUM_INTERRUPTS - 1:0];
    end

    for (genvar t = 0; t < creg_pkg::THREADS_PER_CORE; t++)
    begin : thread_gen
        logic own_write;
        logic [creg_pkg::NUM_INTERRUPTS - 1:0] ack_bits;

        assign own_write = creg_access.write_en
            && creg_access.thread == creg_pkg::thread_idx_t'(t);
        assign ack_bits = (own_write && creg_access.index == creg_pkg::CR_INTERRUPT_ACK)
            ? creg_access.value.raw[creg_pkg::NUM_INTERRUPTS - 1:0] : '0;

        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
            begin
                edge_latched[t] <= '0;
                mask_word[t] <= '0;
            end
            else
            begin
                // A new edge wins over an ack in the same cycle
                edge_latched[t] <= (edge_latched[t] & ~ack_bits) | interrupt_edge;
                if (own_write && creg_access.index == creg_pkg::CR_INTERRUPT_MASK)
                    mask_word[t] <= creg_access.value.raw[creg_pkg::NUM_INTERRUPTS - 1:0];
            end
        end

        // Level lines pass straight through, edge lines come from the latch
        assign pending_word[t] = (trigger_type & interrupt_req)
            | (~trigger_type & edge_latched[t]);

        assign interrupt_pending[t] = |(pending_word[t] & mask_word[t]);
    end

endmodule

/* rtl/thread_context.sv */
module thread_context(
    input                               clk,
    input                               reset,
    input creg_pkg::creg_access_t       creg_access,
    input creg_pkg::trap_event_t        trap,
    input creg_pkg::eret_t              eret,
    output creg_pkg::flags_t            current_flags[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           eret_address[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::subcycle_t         eret_subcycle[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::flags_t            saved_flags[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::trap_cause_t       trap_cause[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           trap_address[creg_pkg::THREADS_PER_CORE],
    output creg_pkg::scalar_t           scratchpad[creg_pkg::THREADS_PER_CORE][2]);

    // State saved on one trap entry
    typedef struct packed {
        creg_pkg::flags_t flags;
        creg_pkg::trap_cause_t cause;
        creg_pkg::scalar_t pc;
        creg_pkg::scalar_t access_addr;
        creg_pkg::subcycle_t subcycle;
    } trap_frame_t;

    // Level 0 is the active trap, level 1 the one it interrupted
    trap_frame_t frame[2][creg_pkg::THREADS_PER_CORE];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int t = 0; t < creg_pkg::THREADS_PER_CORE; t++)
            begin
                // Supervisor mode, MMU and interrupts off
                current_flags[t] <= 3'b100;
                scratchpad[t][0] <= '0;
                scratchpad[t][1] <= '0;
                for (int level = 0; level < 2; level++)
                begin
                    frame[level][t].flags <= 3'b100;
                    frame[level][t].cause <= '{
                        is_store: 1'b0,
                        is_data_access: 1'b0,
                        trap_type: creg_pkg::TT_RESET
                    };
                    frame[level][t].pc <= '0;
                    frame[level][t].access_addr <= '0;
                    frame[level][t].subcycle <= '0;
                end
            end
        end
        else
        begin
            if (creg_access.write_en)
            begin
                case (creg_access.index)
                    creg_pkg::CR_FLAGS:
                        current_flags[creg_access.thread] <= creg_access.value.flag_view.flags;
                    creg_pkg::CR_SAVED_FLAGS:
                        frame[0][creg_access.thread].flags <= creg_access.value.flag_view.flags;
                    creg_pkg::CR_TRAP_PC:
                        frame[0][creg_access.thread].pc <= creg_access.value.raw;
                    creg_pkg::CR_SCRATCHPAD0:
                        scratchpad[creg_access.thread][0] <= creg_access.value.raw;
                    creg_pkg::CR_SCRATCHPAD1:
                        scratchpad[creg_access.thread][1] <= creg_access.value.raw;
                    creg_pkg::CR_SUBCYCLE:
                        frame[0][creg_access.thread].subcycle <=
                            creg_access.value.raw[creg_pkg::SUBCYCLE_WIDTH - 1:0];
                    default:
                        ;
                endcase
            end

            // Comes after the write decode so a trap overrides a write to the same thread
            if (trap.valid)
            begin
                frame[1][trap.thread] <= frame[0][trap.thread];
                frame[0][trap.thread] <= '{
                    flags: current_flags[trap.thread],
                    cause: trap.cause,
                    pc: trap.pc,
                    access_addr: trap.access_addr,
                    subcycle: trap.subcycle
                };
                current_flags[trap.thread].supervisor_en <= 1'b1;
                current_flags[trap.thread].interrupt_en <= 1'b0;
                if (trap.cause.trap_type == creg_pkg::TT_TLB_MISS)
                    current_flags[trap.thread].mmu_en <= 1'b0;
            end
            else if (eret.valid)
            begin
                current_flags[eret.thread] <= frame[0][eret.thread].flags;
                frame[0][eret.thread] <= frame[1][eret.thread];
            end
        end
    end

    always_comb
    begin
        for (int t = 0; t < creg_pkg::THREADS_PER_CORE; t++)
        begin
            eret_address[t] = frame[0][t].pc;
            eret_subcycle[t] = frame[0][t].subcycle;
            saved_flags[t] = frame[0][t].flags;
            trap_cause[t] = frame[0][t].cause;
            trap_address[t] = frame[0][t].access_addr;
        end
    end

    // Writeback raises traps and execute raises erets, never in the same cycle
    trap_eret_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(trap.valid && eret.valid))
        else $error("trap and eret in the same cycle");

endmodule

/* verification/clock_gen.sv */
module clock_gen(
    output logic clk,
    output logic reset);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for three rising edges, released just after the third
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

/* verification/creg_input.txt */
# Operation and hex operands: write|read <register> <thread> <value|expected>,
# trap <thread> <cause> <pc> <addr> <subcycle>, eret <thread>, irq <lines>, wait <cycles>,
# flags <thread> <expected>, pending <expected>, handler <trap> <tlb miss>, cycles <idle>
read FLAGS 0 00000004
pending 0
write SCRATCHPAD0 0 12345678
write SCRATCHPAD1 3 cafef00d
read SCRATCHPAD0 0 12345678
read SCRATCHPAD1 3 cafef00d
read SCRATCHPAD1 0 00000000
write TRAP_HANDLER 0 00001000
write TLB_MISS_HANDLER 2 00002000
handler 00001000 00002000
write CURRENT_ASID 2 000000a5
read CURRENT_ASID 2 000000a5
write PAGE_DIR 1 00ab0000
read PAGE_DIR 1 00ab0000
read THREAD_ID 3 00000007
read 1f 0 ffffffff
write FLAGS 1 fffffff3
flags 1 3
read FLAGS 1 00000003
trap 1 01 00000400 00000000 0
flags 1 6
trap 1 34 00000800 00dead00 5
flags 1 4
read TRAP_CAUSE 1 00000034
read TRAP_ADDRESS 1 00dead00
read SUBCYCLE 1 00000005
eret 1
flags 1 6
read TRAP_PC 1 00000400
eret 1
flags 1 3
flags 0 4
write INTERRUPT_MASK 2 00000001
write INTERRUPT_TRIGGER 0 00000002
irq 0001
irq 0000
pending 4
read INTERRUPT_PENDING 2 00000001
write INTERRUPT_ACK 2 00000001
pending 0
write INTERRUPT_MASK 0 00000002
irq 0002
pending 1
irq 0004
pending 0
wait 2
cycles 3

/* verification/creg_subsystem_tb.sv */
module creg_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES = 200;
    localparam int RESET_TIMEOUT = 50;

    logic clk;
    logic reset;
    logic [creg_pkg::NUM_INTERRUPTS - 1:0] interrupt_req;
    creg_pkg::creg_access_t creg_access;
    creg_pkg::trap_event_t trap;
    creg_pkg::eret_t eret;
    creg_pkg::scalar_t read_value;
    creg_pkg::flags_t current_flags[creg_pkg::THREADS_PER_CORE];
    creg_pkg::scalar_t eret_address[creg_pkg::THREADS_PER_CORE];
    creg_pkg::subcycle_t eret_subcycle[creg_pkg::THREADS_PER_CORE];
    creg_pkg::thread_bitmap_t interrupt_pending;
    creg_pkg::scalar_t trap_handler;
    creg_pkg::scalar_t tlb_miss_handler;
    creg_pkg::asid_t current_asid[creg_pkg::THREADS_PER_CORE];
    creg_pkg::scalar_t page_dir[creg_pkg::THREADS_PER_CORE];
    int checks;
    int value_errors;
    int other_errors;

    clock_gen clock_gen(.clk(clk), .reset(reset));

    creg_subsystem #(.CORE_ID(1)) UUT(
        .clk(clk),
        .reset(reset),
        .interrupt_req(interrupt_req),
        .creg_access(creg_access),
        .trap(trap),
        .eret(eret),
        .read_value(read_value),
        .current_flags(current_flags),
        .eret_address(eret_address),
        .eret_subcycle(eret_subcycle),
        .interrupt_pending(interrupt_pending),
        .trap_handler(trap_handler),
        .tlb_miss_handler(tlb_miss_handler),
        .current_asid(current_asid),
        .page_dir(page_dir));

    task automatic check_scalar(input creg_pkg::scalar_t actual, input creg_pkg::scalar_t expected,
        input string what);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flags(input creg_pkg::flags_t actual, input creg_pkg::flags_t expected,
        input string what);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_pending(input creg_pkg::thread_bitmap_t actual,
        input creg_pkg::thread_bitmap_t expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_asid(input creg_pkg::asid_t actual, input creg_pkg::asid_t expected,
        input string what);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_subcycle(input creg_pkg::subcycle_t actual,
        input creg_pkg::subcycle_t expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Registers that also leave the top level must show the read value on their port
    task automatic check_register_port(input creg_pkg::creg_index_t index,
        input creg_pkg::thread_idx_t thread, input creg_pkg::scalar_t expected);
        case (index)
            creg_pkg::CR_TRAP_PC:
                check_scalar(eret_address[thread], expected,
                    $sformatf("eret_address thread %0d", thread));
            creg_pkg::CR_SUBCYCLE:
                check_subcycle(eret_subcycle[thread], expected[creg_pkg::SUBCYCLE_WIDTH - 1:0],
                    $sformatf("eret_subcycle thread %0d", thread));
            creg_pkg::CR_CURRENT_ASID:
                check_asid(current_asid[thread], expected[creg_pkg::ASID_WIDTH - 1:0],
                    $sformatf("current_asid thread %0d", thread));
            creg_pkg::CR_PAGE_DIR:
                check_scalar(page_dir[thread], expected,
                    $sformatf("page_dir thread %0d", thread));
            default:
                ;
        endcase
    endtask

    // Every drive happens 2 ns after a rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++)
            advance_cycle();
    endtask

    // One cycle strobe; read results are stable once the strobe is cleared
    task automatic pulse_access(input logic is_read, input creg_pkg::creg_index_t index,
        input creg_pkg::thread_idx_t thread, input creg_pkg::scalar_t value);
        advance_cycle();
        creg_access.read_en = is_read;
        creg_access.write_en = !is_read;
        creg_access.index = index;
        creg_access.thread = thread;
        creg_access.value.raw = value;
        advance_cycle();
        creg_access = '0;
    endtask

    task automatic pulse_trap(input int unsigned thread, input int unsigned cause,
        input int unsigned pc, input int unsigned addr, input int unsigned subcycle);
        advance_cycle();
        trap.valid = 1'b1;
        trap.cause = creg_pkg::trap_cause_t'(cause[5:0]);
        trap.pc = pc;
        trap.access_addr = addr;
        trap.thread = creg_pkg::thread_idx_t'(thread[1:0]);
        trap.subcycle = creg_pkg::subcycle_t'(subcycle[3:0]);
        advance_cycle();
        trap = '0;
    endtask

    task automatic pulse_eret(input int unsigned thread);
        advance_cycle();
        eret.valid = 1'b1;
        eret.thread = creg_pkg::thread_idx_t'(thread[1:0]);
        advance_cycle();
        eret = '0;
    endtask

    // Counter sampled at two reads that are gap idle cycles apart
    task automatic count_cycles(input int unsigned gap);
        creg_pkg::scalar_t first;

        pulse_access(1'b1, creg_pkg::CR_CYCLE_COUNT, '0, '0);
        first = read_value;
        // The cycle after a strobe is already idle
        idle_cycles(gap - 1);
        pulse_access(1'b1, creg_pkg::CR_CYCLE_COUNT, '0, '0);
        check_scalar(read_value - first, gap + 1, $sformatf("cycle count over %0d idle", gap));
    endtask

    // Register name without its CR_ prefix, or a raw hex register number
    function automatic logic find_index(input string name, output creg_pkg::creg_index_t index);
        creg_pkg::creg_index_t probe;
        logic [4:0] number;

        probe = probe.first();
        for (int i = 0; i < probe.num(); i++)
        begin
            if (probe.name() == {"CR_", name})
            begin
                index = probe;
                return 1'b1;
            end
            probe = probe.next();
        end
        if ($sscanf(name, "%h", number) == 1)
        begin
            index = creg_pkg::creg_index_t'(number);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_bad_line(input int number, input string line);
        other_errors++;
        $display("Could not read line %0d of the stimulus file: %s", number, line);
    endtask

    task automatic run_file();
        int fd;
        int count;
        string line;
        string op;
        string name;
        int unsigned a;
        int unsigned b;
        int unsigned c;
        int unsigned d;
        int unsigned e;
        creg_pkg::creg_index_t index;

        fd = $fopen("verification/creg_input.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open verification/creg_input.txt");
            return;
        end
        for (int n = 1; n <= MAX_LINES && !$feof(fd); n++)
        begin
            line = "";
            count = $fgets(line, fd);
            if (count == 0 || line.len() < 2 || line[0] == "#")
                continue;
            count = $sscanf(line, "%s", op);
            case (op)
                "write", "read":
                    if ($sscanf(line, "%s %s %h %h", op, name, a, b) != 4 || !find_index(name, index))
                        report_bad_line(n, line);
                    else if (op == "write")
                        pulse_access(1'b0, index, creg_pkg::thread_idx_t'(a[1:0]), b);
                    else
                    begin
                        pulse_access(1'b1, index, creg_pkg::thread_idx_t'(a[1:0]), '0);
                        check_scalar(read_value, b, $sformatf("read %s thread %0d", name, a));
                        check_register_port(index, creg_pkg::thread_idx_t'(a[1:0]), b);
                    end
                "trap":
                    if ($sscanf(line, "%s %h %h %h %h %h", op, a, b, c, d, e) != 6)
                        report_bad_line(n, line);
                    else
                        pulse_trap(a, b, c, d, e);
                "eret":
                    if ($sscanf(line, "%s %h", op, a) != 2)
                        report_bad_line(n, line);
                    else
                        pulse_eret(a);
                "irq":
                    if ($sscanf(line, "%s %h", op, a) != 2)
                        report_bad_line(n, line);
                    else
                    begin
                        advance_cycle();
                        interrupt_req = a[creg_pkg::NUM_INTERRUPTS - 1:0];
                        // Give an edge one cycle to reach the latches
                        advance_cycle();
                    end
                "wait":
                    if ($sscanf(line, "%s %h", op, a) != 2)
                        report_bad_line(n, line);
                    else
                        idle_cycles(a);
                "flags":
                    if ($sscanf(line, "%s %h %h", op, a, b) != 3)
                        report_bad_line(n, line);
                    else
                        check_flags(current_flags[a[1:0]], creg_pkg::flags_t'(b[2:0]),
                            $sformatf("current_flags thread %0d", a));
                "pending":
                    if ($sscanf(line, "%s %h", op, a) != 2)
                        report_bad_line(n, line);
                    else
                        check_pending(interrupt_pending, creg_pkg::thread_bitmap_t'(a[3:0]),
                            "interrupt_pending");
                "handler":
                    if ($sscanf(line, "%s %h %h", op, a, b) != 3)
                        report_bad_line(n, line);
                    else
                    begin
                        check_scalar(trap_handler, a, "trap_handler");
                        check_scalar(tlb_miss_handler, b, "tlb_miss_handler");
                    end
                "cycles":
                    if ($sscanf(line, "%s %h", op, a) != 2 || a == 0)
                        report_bad_line(n, line);
                    else
                        count_cycles(a);
                default:
                    report_bad_line(n, line);
            endcase
            if (op != "cycles")
                idle_cycles($urandom % 4);
        end
        $fclose(fd);
    endtask

    task automatic wait_for_reset(output logic released);
        released = 1'b0;
        for (int i = 0; i < RESET_TIMEOUT && !released; i++)
        begin
            @(posedge clk);
            released = !reset;
        end
        if (!released)
        begin
            other_errors++;
            $display("Timed out waiting for reset to be released");
        end
        #2;
    endtask

    task automatic finish_run();
        $display("Checks: %0d, wrong values: %0d, other errors: %0d",
            checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    endtask

    initial
    begin
        logic released;

        interrupt_req = '0;
        creg_access = '0;
        trap = '0;
        eret = '0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'h5c7d));
        wait_for_reset(released);
        if (released)
        begin
            check_scalar(read_value, '0, "read_value after reset");
            run_file();
        end
        finish_run();
    end

endmodule
